// ==== hw/pix_pkg.sv ====
// **************************************************************************
// Pixel shading package.
// RGB565 color struct, channel widths and fixed-point scale helpers.
// **************************************************************************
`default_nettype none

package pix_pkg;

	localparam int COLOR_W = 16;                    // Packed RGB565.
	localparam int RED_W = 5;
	localparam int GREEN_W = 6;
	localparam int BLUE_W = 5;

	localparam int SCALE_W = 6;                     // Brightness and alpha.
	localparam int SCALE_MAX = (1 << SCALE_W) - 1;  // Full scale, 63.

	// Product of the widest channel and a factor of up to 2^SCALE_W.
	localparam int PROD_W = GREEN_W + SCALE_W + 1;

	typedef struct packed {
		logic [RED_W-1:0]   red;                    // Bits 15:11.
		logic [GREEN_W-1:0] green;                  // Bits 10:5.
		logic [BLUE_W-1:0]  blue;                   // Bits 4:0.
	} pix_color_t;

	// Channel times scale factor, zero extended to the full product width.
	// Narrow channels are passed zero extended to GREEN_W.
	function automatic logic [PROD_W-1:0] pix_mul(
		input logic [GREEN_W-1:0] chan,
		input logic [SCALE_W:0]   factor
	);
		return PROD_W'(chan) * PROD_W'(factor);
	endfunction

endpackage

`default_nettype wire

// ==== hw/pix_pipe_reg.sv ====
// **************************************************************************
// One-entry valid/ready pipeline register for an arbitrary payload type.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic     sys_clk,
	input  wire logic     sys_rst,

	input  wire logic     valid_i,
	input  wire payload_t data_i,
	output logic          ready_o,

	output logic          valid_o,
	output payload_t      data_o,
	input  wire logic     ready_i
);

	logic     valid_q;
	payload_t data_q;

	assign ready_o = !valid_q || ready_i;     // Empty or draining now.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_q <= 1'b0;
		end else if (ready_o) begin
			valid_q <= valid_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ready_o && valid_i) begin
			data_q <= data_i;                   // Load on transfer in.
		end
	end

	assign valid_o = valid_q;
	assign data_o  = data_q;

	// A stalled output keeps its item until the consumer takes it.
	a_hold_stalled: assert property (@(posedge sys_clk) disable iff (sys_rst)
		valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// ==== hw/pix_decode.sv ====
// **************************************************************************
// Decode stage, unpacks pixels and drops chroma-keyed ones.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_decode #(
	parameter int ADR_W = 25
) (
	input  wire logic                        sys_clk,
	input  wire logic                        sys_rst,

	input  wire logic                        in_valid_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] in_color_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] in_dcolor_i,
	input  wire logic [ADR_W-1:0]            in_dadr_i,
	output logic                             in_ready_o,

	input  wire logic                        chroma_key_en_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] chroma_key_i,

	output logic                             out_valid_o,
	output pix_pkg::pix_color_t              out_src_o,
	output pix_pkg::pix_color_t              out_dst_o,
	output logic [ADR_W-1:0]                 out_dadr_o,
	input  wire logic                        out_ready_i
);

	import pix_pkg::*;

	typedef struct packed {
		pix_color_t       src;
		pix_color_t       dst;
		logic [ADR_W-1:0] dadr;
	} dec_payload_t;

	logic         keyed;
	dec_payload_t dec_d;
	dec_payload_t dec_q;

	assign keyed = chroma_key_en_i && (in_color_i == chroma_key_i);

	assign dec_d.src  = pix_color_t'(in_color_i);
	assign dec_d.dst  = pix_color_t'(in_dcolor_i);
	assign dec_d.dadr = in_dadr_i;

	// A keyed pixel is consumed but never loaded.
	pix_pipe_reg #(
		.payload_t(dec_payload_t)
	) i_pipe_reg (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.valid_i(in_valid_i && !keyed),
		.data_i (dec_d),
		.ready_o(in_ready_o),
		.valid_o(out_valid_o),
		.data_o (dec_q),
		.ready_i(out_ready_i)
	);

	assign out_src_o  = dec_q.src;
	assign out_dst_o  = dec_q.dst;
	assign out_dadr_o = dec_q.dadr;

endmodule

`default_nettype wire

// ==== hw/pix_execute.sv ====
// **************************************************************************
// Execute stage, applies the brightness decay to the source color.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_execute #(
	parameter int ADR_W = 25
) (
	input  wire logic                        sys_clk,
	input  wire logic                        sys_rst,

	input  wire logic                        in_valid_i,
	input  wire pix_pkg::pix_color_t         in_src_i,
	input  wire pix_pkg::pix_color_t         in_dst_i,
	input  wire logic [ADR_W-1:0]            in_dadr_i,
	output logic                             in_ready_o,

	input  wire logic [pix_pkg::SCALE_W-1:0] brightness_i,

	output logic                             out_valid_o,
	output pix_pkg::pix_color_t              out_src_o,
	output pix_pkg::pix_color_t              out_dst_o,
	output logic [ADR_W-1:0]                 out_dadr_o,
	input  wire logic                        out_ready_i
);

	import pix_pkg::*;

	typedef struct packed {
		pix_color_t       src;
		pix_color_t       dst;
		logic [ADR_W-1:0] dadr;
	} exe_payload_t;

	logic [SCALE_W:0]  factor;
	logic [PROD_W-1:0] red_prod;
	logic [PROD_W-1:0] green_prod;
	logic [PROD_W-1:0] blue_prod;
	exe_payload_t      exe_d;
	exe_payload_t      exe_q;

	assign factor = {1'b0, brightness_i} + (SCALE_W+1)'(1);   // 1 to 64.

	assign red_prod   = pix_mul(GREEN_W'(in_src_i.red), factor);
	assign green_prod = pix_mul(in_src_i.green, factor);
	assign blue_prod  = pix_mul(GREEN_W'(in_src_i.blue), factor);

	// Drop the fractional bits of the scale factor.
	assign exe_d.src.red   = red_prod[RED_W+SCALE_W-1:SCALE_W];
	assign exe_d.src.green = green_prod[GREEN_W+SCALE_W-1:SCALE_W];
	assign exe_d.src.blue  = blue_prod[BLUE_W+SCALE_W-1:SCALE_W];
	assign exe_d.dst       = in_dst_i;
	assign exe_d.dadr      = in_dadr_i;

	pix_pipe_reg #(
		.payload_t(exe_payload_t)
	) i_pipe_reg (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.valid_i(in_valid_i),
		.data_i (exe_d),
		.ready_o(in_ready_o),
		.valid_o(out_valid_o),
		.data_o (exe_q),
		.ready_i(out_ready_i)
	);

	assign out_src_o  = exe_q.src;
	assign out_dst_o  = exe_q.dst;
	assign out_dadr_o = exe_q.dadr;

endmodule

`default_nettype wire

// ==== hw/pix_result.sv ====
// **************************************************************************
// Result stage, alpha-blends source over destination and repacks RGB565.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_result #(
	parameter int ADR_W = 25
) (
	input  wire logic                        sys_clk,
	input  wire logic                        sys_rst,

	input  wire logic                        in_valid_i,
	input  wire pix_pkg::pix_color_t         in_src_i,
	input  wire pix_pkg::pix_color_t         in_dst_i,
	input  wire logic [ADR_W-1:0]            in_dadr_i,
	output logic                             in_ready_o,

	input  wire logic [pix_pkg::SCALE_W-1:0] alpha_i,

	output logic                             out_valid_o,
	output logic [pix_pkg::COLOR_W-1:0]      out_color_o,
	output logic [ADR_W-1:0]                 out_dadr_o,
	input  wire logic                        out_ready_i
);

	import pix_pkg::*;

	typedef struct packed {
		pix_color_t       color;
		logic [ADR_W-1:0] dadr;
	} res_payload_t;

	logic [SCALE_W:0] src_factor;
	logic [SCALE_W:0] dst_factor;
	logic [PROD_W:0]  red_sum;
	logic [PROD_W:0]  green_sum;
	logic [PROD_W:0]  blue_sum;
	res_payload_t     res_d;
	res_payload_t     res_q;

	assign src_factor = {1'b0, alpha_i} + (SCALE_W+1)'(1);          // Alpha plus one.
	assign dst_factor = {1'b0, SCALE_W'(SCALE_MAX) - alpha_i};      // Remaining weight.

	assign red_sum = {1'b0, pix_mul(GREEN_W'(in_src_i.red), src_factor)}
		+ {1'b0, pix_mul(GREEN_W'(in_dst_i.red), dst_factor)};
	assign green_sum = {1'b0, pix_mul(in_src_i.green, src_factor)}
		+ {1'b0, pix_mul(in_dst_i.green, dst_factor)};
	assign blue_sum = {1'b0, pix_mul(GREEN_W'(in_src_i.blue), src_factor)}
		+ {1'b0, pix_mul(GREEN_W'(in_dst_i.blue), dst_factor)};

	assign res_d.color.red   = red_sum[RED_W+SCALE_W-1:SCALE_W];
	assign res_d.color.green = green_sum[GREEN_W+SCALE_W-1:SCALE_W];
	assign res_d.color.blue  = blue_sum[BLUE_W+SCALE_W-1:SCALE_W];
	assign res_d.dadr        = in_dadr_i;

	pix_pipe_reg #(
		.payload_t(res_payload_t)
	) i_pipe_reg (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.valid_i(in_valid_i),
		.data_i (res_d),
		.ready_o(in_ready_o),
		.valid_o(out_valid_o),
		.data_o (res_q),
		.ready_i(out_ready_i)
	);

	assign out_color_o = res_q.color;    // Packed back to RGB565.
	assign out_dadr_o  = res_q.dadr;

	// The two blend weights sum to 64, so no channel may overflow.
	a_no_overflow: assert property (@(posedge sys_clk) disable iff (sys_rst)
		in_valid_i |-> (red_sum[PROD_W:RED_W+SCALE_W] == '0)
			&& (green_sum[PROD_W:GREEN_W+SCALE_W] == '0)
			&& (blue_sum[PROD_W:BLUE_W+SCALE_W] == '0));

endmodule

`default_nettype wire

// ==== hw/pix_shade_top.sv ====
// **************************************************************************
// Pixel shading back end, chroma key, brightness decay and alpha blend.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_shade_top #(
	parameter int ADR_W = 25
) (
	input  wire logic                        sys_clk,
	input  wire logic                        sys_rst,

	input  wire logic                        in_valid_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] in_color_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] in_dcolor_i,
	input  wire logic [ADR_W-1:0]            in_dadr_i,
	output logic                             in_ready_o,

	input  wire logic [pix_pkg::SCALE_W-1:0] brightness_i,
	input  wire logic                        chroma_key_en_i,
	input  wire logic [pix_pkg::COLOR_W-1:0] chroma_key_i,
	input  wire logic [pix_pkg::SCALE_W-1:0] alpha_i,

	output logic                             out_valid_o,
	output logic [pix_pkg::COLOR_W-1:0]      out_color_o,
	output logic [ADR_W-1:0]                 out_dadr_o,
	input  wire logic                        out_ready_i
);

	import pix_pkg::*;

	logic             dec_valid;
	logic             dec_ready;
	pix_color_t       dec_src;
	pix_color_t       dec_dst;
	logic [ADR_W-1:0] dec_dadr;

	logic             exe_valid;
	logic             exe_ready;
	pix_color_t       exe_src;
	pix_color_t       exe_dst;
	logic [ADR_W-1:0] exe_dadr;

	pix_decode #(
		.ADR_W(ADR_W)
	) i_decode (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.in_valid_i     (in_valid_i),
		.in_color_i     (in_color_i),
		.in_dcolor_i    (in_dcolor_i),
		.in_dadr_i      (in_dadr_i),
		.in_ready_o     (in_ready_o),
		.chroma_key_en_i(chroma_key_en_i),
		.chroma_key_i   (chroma_key_i),
		.out_valid_o    (dec_valid),
		.out_src_o      (dec_src),
		.out_dst_o      (dec_dst),
		.out_dadr_o     (dec_dadr),
		.out_ready_i    (dec_ready)
	);

	pix_execute #(
		.ADR_W(ADR_W)
	) i_execute (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.in_valid_i  (dec_valid),
		.in_src_i    (dec_src),
		.in_dst_i    (dec_dst),
		.in_dadr_i   (dec_dadr),
		.in_ready_o  (dec_ready),
		.brightness_i(brightness_i),
		.out_valid_o (exe_valid),
		.out_src_o   (exe_src),
		.out_dst_o   (exe_dst),
		.out_dadr_o  (exe_dadr),
		.out_ready_i (exe_ready)
	);

	pix_result #(
		.ADR_W(ADR_W)
	) i_result (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.in_valid_i (exe_valid),
		.in_src_i   (exe_src),
		.in_dst_i   (exe_dst),
		.in_dadr_i  (exe_dadr),
		.in_ready_o (exe_ready),
		.alpha_i    (alpha_i),
		.out_valid_o(out_valid_o),
		.out_color_o(out_color_o),
		.out_dadr_o (out_dadr_o),
		.out_ready_i(out_ready_i)
	);

endmodule

`default_nettype wire

// ==== dv/pix_shade_tb.sv ====
// **************************************************************************
// Testbench for the pixel shading back end.
// Table-driven pixels checked against a model, with and without back-pressure.
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_shade_tb;

	import pix_pkg::*;

	localparam int ADR_W = 25;
	localparam int CLK_PERIOD = 20;
	localparam int N_ENTRIES = 18;
	localparam int WD_CYCLES = N_ENTRIES * 2 * 30 + 100;

	logic                 sys_clk;
	logic                 sys_rst;
	logic                 in_valid_i;
	logic [COLOR_W-1:0]   in_color_i;
	logic [COLOR_W-1:0]   in_dcolor_i;
	logic [ADR_W-1:0]     in_dadr_i;
	logic                 in_ready_o;
	logic [SCALE_W-1:0]   brightness_i;
	logic                 chroma_key_en_i;
	logic [COLOR_W-1:0]   chroma_key_i;
	logic [SCALE_W-1:0]   alpha_i;
	logic                 out_valid_o;
	logic [COLOR_W-1:0]   out_color_o;
	logic [ADR_W-1:0]     out_dadr_o;
	logic                 out_ready_i;

	// Stimulus table, one pixel per entry.
	string                t_name [N_ENTRIES];
	logic [COLOR_W-1:0]   t_src [N_ENTRIES];
	logic [COLOR_W-1:0]   t_dst [N_ENTRIES];
	logic [ADR_W-1:0]     t_adr [N_ENTRIES];
	logic [SCALE_W-1:0]   t_bri [N_ENTRIES];
	logic                 t_key_en [N_ENTRIES];
	logic [COLOR_W-1:0]   t_key [N_ENTRIES];
	logic [SCALE_W-1:0]   t_alpha [N_ENTRIES];
	logic                 t_kept [N_ENTRIES];
	int                   n_loaded;

	// Pixels in flight, oldest first.
	logic [COLOR_W-1:0]   exp_color_q [$];
	logic [ADR_W-1:0]     exp_adr_q [$];
	int                   exp_idx_q [$];
	int                   exp_cyc_q [$];

	int                   cycle_cnt;
	int                   check_cnt;
	int                   error_cnt;
	int                   seed;
	logic                 bp_en;

	pix_shade_top #(
		.ADR_W(ADR_W)
	) i_pix_shade_top (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.in_valid_i     (in_valid_i),
		.in_color_i     (in_color_i),
		.in_dcolor_i    (in_dcolor_i),
		.in_dadr_i      (in_dadr_i),
		.in_ready_o     (in_ready_o),
		.brightness_i   (brightness_i),
		.chroma_key_en_i(chroma_key_en_i),
		.chroma_key_i   (chroma_key_i),
		.alpha_i        (alpha_i),
		.out_valid_o    (out_valid_o),
		.out_color_o    (out_color_o),
		.out_dadr_o     (out_dadr_o),
		.out_ready_i    (out_ready_i)
	);

	always #(CLK_PERIOD / 2) sys_clk = !sys_clk;

	// Decay then blend, channel by channel.
	function automatic logic [COLOR_W-1:0] shade_model(input logic [COLOR_W-1:0] src,
		input logic [COLOR_W-1:0] dst, input int bri, input int alpha);
		pix_color_t s;
		pix_color_t d;
		int red;
		int grn;
		int blu;
		s = src;
		d = dst;
		red = s.red * (bri + 1) / (SCALE_MAX + 1);
		grn = s.green * (bri + 1) / (SCALE_MAX + 1);
		blu = s.blue * (bri + 1) / (SCALE_MAX + 1);
		red = (red * (alpha + 1) + d.red * (SCALE_MAX - alpha)) / (SCALE_MAX + 1);
		grn = (grn * (alpha + 1) + d.green * (SCALE_MAX - alpha)) / (SCALE_MAX + 1);
		blu = (blu * (alpha + 1) + d.blue * (SCALE_MAX - alpha)) / (SCALE_MAX + 1);
		return {red[4:0], grn[5:0], blu[4:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_cnt++;
		if (exp !== act) begin
			error_cnt++;
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic add_entry(input string name, input logic [15:0] src, input logic [15:0] dst,
		input logic [ADR_W-1:0] adr, input logic [5:0] bri, input logic key_en,
		input logic [15:0] key, input logic [5:0] alpha, input logic kept);
		t_name[n_loaded]   = name;
		t_src[n_loaded]    = src;
		t_dst[n_loaded]    = dst;
		t_adr[n_loaded]    = adr;
		t_bri[n_loaded]    = bri;
		t_key_en[n_loaded] = key_en;
		t_key[n_loaded]    = key;
		t_alpha[n_loaded]  = alpha;
		t_kept[n_loaded]   = kept;
		n_loaded++;
	endtask

	task automatic load_table();
		//        name     src       dst       adr          bri  key_en key  alpha kept
		add_entry("pass_w", 16'hFFFF, 16'h0000, 25'h0000010, 63, 0, 16'h0000, 63, 1);
		add_entry("pass_r", 16'hF800, 16'h1234, 25'h1ABCDEF, 63, 0, 16'h0000, 63, 1);
		add_entry("pass_m", 16'h7BEF, 16'hFFFF, 25'h0000100, 63, 0, 16'h0000, 63, 1);
		add_entry("pass_k", 16'h0000, 16'hFFFF, 25'h1FFFFFF, 63, 0, 16'h0000, 63, 1);
		add_entry("dec_0", 16'hFFFF, 16'h0000, 25'h0000200, 0, 0, 16'h0000, 63, 1);
		add_entry("dec_31a", 16'hFFFF, 16'h0000, 25'h0000201, 31, 0, 16'h0000, 63, 1);
		add_entry("dec_31b", 16'h8A52, 16'h0000, 25'h0000202, 31, 0, 16'h0000, 63, 1);
		add_entry("dec_48a", 16'hF81F, 16'h0000, 25'h0000203, 48, 0, 16'h0000, 63, 1);
		add_entry("dec_48b", 16'h07E0, 16'h0000, 25'h0000204, 48, 0, 16'h0000, 63, 1);
		add_entry("key_pre", 16'h1234, 16'h0000, 25'h0000300, 63, 1, 16'hF81F, 63, 1);
		add_entry("key_hit1", 16'hF81F, 16'h0000, 25'h0000301, 63, 1, 16'hF81F, 63, 0);
		add_entry("key_hit2", 16'hF81F, 16'h5555, 25'h0000302, 63, 1, 16'hF81F, 63, 0);
		add_entry("key_post", 16'hF81E, 16'h0000, 25'h0000303, 63, 1, 16'hF81F, 63, 1);
		add_entry("alp_0", 16'hFFFF, 16'h1234, 25'h0000400, 63, 0, 16'h0000, 0, 1);
		add_entry("alp_20", 16'hF800, 16'h07FF, 25'h0000401, 63, 0, 16'h0000, 20, 1);
		add_entry("alp_40a", 16'h07E0, 16'hF81F, 25'h0000402, 63, 0, 16'h0000, 40, 1);
		add_entry("alp_40b", 16'h39E7, 16'hC618, 25'h0000403, 63, 0, 16'h0000, 40, 1);
		add_entry("dec_alp", 16'hABCD, 16'h5432, 25'h0000500, 20, 0, 16'h0000, 40, 1);
	endtask

	// Waits until every kept pixel has left the pipeline.
	task automatic wait_drain();
		while (exp_color_q.size() != 0) begin
			@(posedge sys_clk);
			#2;
		end
	endtask

	// Entered and left 2 ns after a rising edge.
	task automatic drive_entry(input int i);
		logic taken;
		if (brightness_i !== t_bri[i] || chroma_key_en_i !== t_key_en[i]
			|| chroma_key_i !== t_key[i] || alpha_i !== t_alpha[i]) begin
			wait_drain();
		end
		brightness_i    = t_bri[i];
		chroma_key_en_i = t_key_en[i];
		chroma_key_i    = t_key[i];
		alpha_i         = t_alpha[i];
		in_valid_i      = 1'b1;
		in_color_i      = t_src[i];
		in_dcolor_i     = t_dst[i];
		in_dadr_i       = t_adr[i];
		taken = 1'b0;
		while (!taken) begin
			@(posedge sys_clk);
			taken = in_ready_o;
		end
		if (t_kept[i]) begin
			exp_color_q.push_back(shade_model(t_src[i], t_dst[i], t_bri[i], t_alpha[i]));
			exp_adr_q.push_back(t_adr[i]);
			exp_idx_q.push_back(i);
			exp_cyc_q.push_back(cycle_cnt);
		end
		#2;
		in_valid_i = 1'b0;
	endtask

	always @(posedge sys_clk) begin
		out_ready_i <= #2 bp_en ? 1'($random(seed)) : 1'b1;   // Random stall pattern.
	end

	// Output monitor.
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!sys_rst && out_valid_o && out_ready_i) begin
			if (exp_color_q.size() == 0) begin
				error_cnt++;
				$display("Output pixel at address 0x%0h arrived with none expected", out_dadr_o);
			end else begin
				check_value({t_name[exp_idx_q[0]], ".color"}, exp_color_q[0], out_color_o);
				check_value({t_name[exp_idx_q[0]], ".adr"}, exp_adr_q[0], out_dadr_o);
				if (!bp_en) begin
					check_value({t_name[exp_idx_q[0]], ".latency"}, 3, cycle_cnt - exp_cyc_q[0]);
				end
				void'(exp_color_q.pop_front());
				void'(exp_adr_q.pop_front());
				void'(exp_idx_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end
		end
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Timeout, the pipeline stopped delivering pixels");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		in_valid_i = 1'b0;
		in_color_i = '0;
		in_dcolor_i = '0;
		in_dadr_i = '0;
		brightness_i = 6'd63;
		chroma_key_en_i = 1'b0;
		chroma_key_i = '0;
		alpha_i = 6'd63;
		out_ready_i = 1'b1;
		bp_en = 1'b0;
		seed = 43;
		cycle_cnt = 0;
		check_cnt = 0;
		error_cnt = 0;
		n_loaded = 0;
		load_table();
		repeat (4) @(posedge sys_clk);
		#2;
		sys_rst = 1'b0;
		@(posedge sys_clk);
		check_value("after_reset.valid", 0, out_valid_o);
		#2;
		for (int pass = 0; pass < 2; pass++) begin
			bp_en = (pass == 1);                    // Second pass stalls the output.
			for (int i = 0; i < N_ENTRIES; i++) begin
				drive_entry(i);
			end
			wait_drain();
		end
		repeat (10) @(posedge sys_clk);             // Catch stray outputs.
		$display("%0d checks, %0d errors", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/pix_pkg.sv
hw/pix_pipe_reg.sv
hw/pix_decode.sv
hw/pix_execute.sv
hw/pix_result.sv
hw/pix_shade_top.sv
dv/pix_shade_tb.sv

// ==== Bender.yml ====
package:
  name: pix_shade

sources:
  - files:
      - hw/pix_pkg.sv
      - hw/pix_pipe_reg.sv
      - hw/pix_decode.sv
      - hw/pix_execute.sv
      - hw/pix_result.sv
      - hw/pix_shade_top.sv
  - target: test
    files:
      - dv/pix_shade_tb.sv
